// File: logic/axi_pkg.sv
package axi_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;
    localparam int strb_w = 4;

    localparam logic [addr_w-1:0] sram_base = 32'h8000_0000;
    localparam logic [addr_w-1:0] sram_last = 32'h8FFF_FFFF;
    localparam logic [addr_w-1:0] uart_base = 32'hA000_0000;
    localparam logic [addr_w-1:0] uart_last = 32'hA000_0007;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;
    localparam logic [1:0] resp_decerr = 2'b11;

    localparam logic [1:0] burst_incr = 2'b01;

    localparam logic [2:0] uart_txdata_off = 3'd0; // Write loads the byte to send.
    localparam logic [2:0] uart_status_off = 3'd4; // Bit 0 is the busy flag.

    typedef enum logic [1:0] {
        tgt_sram,
        tgt_uart,
        tgt_none
    } target_e;

endpackage

// File: logic/axi_if.sv
`timescale 1ns/1ps

interface axi_if import axi_pkg::*; ();

    logic              awvalid, awready;
    logic [addr_w-1:0] awaddr;
    logic [id_w-1:0]   awid;
    logic [7:0]        awlen;
    logic [2:0]        awsize;
    logic [1:0]        awburst;

    logic              wvalid, wready;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              wlast;

    logic              bvalid, bready;
    logic [1:0]        bresp;
    logic [id_w-1:0]   bid;

    logic              arvalid, arready;
    logic [addr_w-1:0] araddr;
    logic [id_w-1:0]   arid;
    logic [7:0]        arlen;
    logic [2:0]        arsize;
    logic [1:0]        arburst;

    logic              rvalid, rready;
    logic [data_w-1:0] rdata;
    logic [1:0]        rresp;
    logic              rlast;
    logic [id_w-1:0]   rid;

    modport mgr (
        output awvalid, awaddr, awid, awlen, awsize, awburst,
        output wvalid, wdata, wstrb, wlast, bready,
        output arvalid, araddr, arid, arlen, arsize, arburst, rready,
        input  awready, wready, bvalid, bresp, bid,
        input  arready, rvalid, rdata, rresp, rlast, rid
    );

    modport sub (
        input  awvalid, awaddr, awid, awlen, awsize, awburst,
        input  wvalid, wdata, wstrb, wlast, bready,
        input  arvalid, araddr, arid, arlen, arsize, arburst, rready,
        output awready, wready, bvalid, bresp, bid,
        output arready, rvalid, rdata, rresp, rlast, rid
    );

endinterface

// File: logic/axi_bridge.sv
`timescale 1ns/1ps

module axi_bridge import axi_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    axi_if.sub   up,
    axi_if.mgr   sram_bus,
    axi_if.mgr   uart_bus
);

    target_e         aw_tgt, ar_tgt;
    target_e         wr_tgt, rd_tgt;
    logic            wr_busy, rd_busy;
    logic [id_w-1:0] wr_id, rd_id;
    logic            err_bvalid, err_rvalid;
    logic [7:0]      err_cnt;
    logic            aw_go, ar_go, b_done, r_done;

    function automatic target_e decode(input logic [addr_w-1:0] addr);
        if (addr >= sram_base && addr <= sram_last) return tgt_sram;
        if (addr >= uart_base && addr <= uart_last) return tgt_uart;
        return tgt_none;
    endfunction

    assign aw_tgt = decode(up.awaddr);
    assign ar_tgt = decode(up.araddr);

    assign sram_bus.awaddr  = up.awaddr;
    assign sram_bus.awid    = up.awid;
    assign sram_bus.awlen   = up.awlen;
    assign sram_bus.awsize  = up.awsize;
    assign sram_bus.awburst = up.awburst;
    assign sram_bus.wdata   = up.wdata;
    assign sram_bus.wstrb   = up.wstrb;
    assign sram_bus.wlast   = up.wlast;
    assign sram_bus.araddr  = up.araddr;
    assign sram_bus.arid    = up.arid;
    assign sram_bus.arlen   = up.arlen;
    assign sram_bus.arsize  = up.arsize;
    assign sram_bus.arburst = up.arburst;

    assign uart_bus.awaddr  = up.awaddr;
    assign uart_bus.awid    = up.awid;
    assign uart_bus.awlen   = up.awlen;
    assign uart_bus.awsize  = up.awsize;
    assign uart_bus.awburst = up.awburst;
    assign uart_bus.wdata   = up.wdata;
    assign uart_bus.wstrb   = up.wstrb;
    assign uart_bus.wlast   = up.wlast;
    assign uart_bus.araddr  = up.araddr;
    assign uart_bus.arid    = up.arid;
    assign uart_bus.arlen   = up.arlen;
    assign uart_bus.arsize  = up.arsize;
    assign uart_bus.arburst = up.arburst;

    // Address valids follow the live decode, data and responses the latched one.
    assign sram_bus.awvalid = up.awvalid && !wr_busy && aw_tgt == tgt_sram;
    assign uart_bus.awvalid = up.awvalid && !wr_busy && aw_tgt == tgt_uart;
    assign sram_bus.wvalid  = up.wvalid && wr_busy && wr_tgt == tgt_sram;
    assign uart_bus.wvalid  = up.wvalid && wr_busy && wr_tgt == tgt_uart;
    assign sram_bus.bready  = up.bready && wr_busy && wr_tgt == tgt_sram;
    assign uart_bus.bready  = up.bready && wr_busy && wr_tgt == tgt_uart;
    assign sram_bus.arvalid = up.arvalid && !rd_busy && ar_tgt == tgt_sram;
    assign uart_bus.arvalid = up.arvalid && !rd_busy && ar_tgt == tgt_uart;
    assign sram_bus.rready  = up.rready && rd_busy && rd_tgt == tgt_sram;
    assign uart_bus.rready  = up.rready && rd_busy && rd_tgt == tgt_uart;

    always_comb begin
        case (aw_tgt)
            tgt_sram: up.awready = !wr_busy && sram_bus.awready;
            tgt_uart: up.awready = !wr_busy && uart_bus.awready;
            default:  up.awready = !wr_busy;
        endcase
        case (ar_tgt)
            tgt_sram: up.arready = !rd_busy && sram_bus.arready;
            tgt_uart: up.arready = !rd_busy && uart_bus.arready;
            default:  up.arready = !rd_busy;
        endcase
    end

    always_comb begin
        case (wr_tgt)
            tgt_sram: begin
                up.wready = wr_busy && sram_bus.wready;
                up.bvalid = wr_busy && sram_bus.bvalid;
                up.bresp  = sram_bus.bresp;
                up.bid    = sram_bus.bid;
            end
            tgt_uart: begin
                up.wready = wr_busy && uart_bus.wready;
                up.bvalid = wr_busy && uart_bus.bvalid;
                up.bresp  = uart_bus.bresp;
                up.bid    = uart_bus.bid;
            end
            default: begin
                up.wready = wr_busy && !err_bvalid; // Sink beats until wlast.
                up.bvalid = err_bvalid;
                up.bresp  = resp_decerr;
                up.bid    = wr_id;
            end
        endcase
    end

    always_comb begin
        case (rd_tgt)
            tgt_sram: begin
                up.rvalid = rd_busy && sram_bus.rvalid;
                up.rdata  = sram_bus.rdata;
                up.rresp  = sram_bus.rresp;
                up.rlast  = sram_bus.rlast;
                up.rid    = sram_bus.rid;
            end
            tgt_uart: begin
                up.rvalid = rd_busy && uart_bus.rvalid;
                up.rdata  = uart_bus.rdata;
                up.rresp  = uart_bus.rresp;
                up.rlast  = uart_bus.rlast;
                up.rid    = uart_bus.rid;
            end
            default: begin
                up.rvalid = err_rvalid;
                up.rdata  = '0;
                up.rresp  = resp_decerr;
                up.rlast  = (err_cnt == 8'd0);
                up.rid    = rd_id;
            end
        endcase
    end

    assign aw_go  = up.awvalid && up.awready;
    assign ar_go  = up.arvalid && up.arready;
    assign b_done = up.bvalid && up.bready;
    assign r_done = up.rvalid && up.rready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_busy    <= 1'b0;
            wr_tgt     <= tgt_none;
            err_bvalid <= 1'b0;
        end else begin
            if (aw_go) begin
                wr_busy <= 1'b1;
                wr_tgt  <= aw_tgt;
            end else if (b_done) begin
                wr_busy <= 1'b0;
            end
            if (wr_busy && wr_tgt == tgt_none && up.wvalid && up.wready && up.wlast) begin
                err_bvalid <= 1'b1;
            end else if (b_done) begin
                err_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_busy    <= 1'b0;
            rd_tgt     <= tgt_none;
            err_rvalid <= 1'b0;
            err_cnt    <= 8'd0;
        end else if (ar_go) begin
            rd_busy    <= 1'b1;
            rd_tgt     <= ar_tgt;
            err_rvalid <= (ar_tgt == tgt_none);
            err_cnt    <= up.arlen;
        end else if (r_done) begin
            if (up.rlast) begin
                rd_busy    <= 1'b0;
                err_rvalid <= 1'b0;
            end else begin
                err_cnt <= err_cnt - 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_go) wr_id <= up.awid;
        if (ar_go) rd_id <= up.arid;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        wr_busy && !b_done |=> wr_busy && $stable(wr_tgt));

    // An address taken by a target locks the write routing to that target.
    assert property (@(posedge clk) disable iff (!rst_n)
        sram_bus.awvalid && sram_bus.awready |=> wr_busy && wr_tgt == tgt_sram);

    assert property (@(posedge clk) disable iff (!rst_n)
        uart_bus.awvalid && uart_bus.awready |=> wr_busy && wr_tgt == tgt_uart);

endmodule

// File: logic/axi_sram.sv
`timescale 1ns/1ps

module axi_sram import axi_pkg::*; #(
    parameter int sram_depth_words = 1024
) (
    input  logic clk,
    input  logic rst_n,
    axi_if.sub   bus
);

    localparam int idx_w = $clog2(sram_depth_words);

    typedef enum logic [1:0] {
        w_idle,
        w_data,
        w_resp
    } wstate_e;

    wstate_e           wstate;
    logic              r_active;
    logic [7:0]        r_cnt;
    logic [idx_w-1:0]  w_idx, r_idx, ar_idx;
    logic [id_w-1:0]   b_id, r_id;
    logic [data_w-1:0] r_data;
    logic [data_w-1:0] mem [sram_depth_words];
    logic              aw_go, w_go, ar_go, r_go;

    assign bus.awready = (wstate == w_idle);
    assign bus.wready  = (wstate == w_data);
    assign bus.bvalid  = (wstate == w_resp);
    assign bus.bresp   = resp_okay;
    assign bus.bid     = b_id;

    assign bus.arready = !r_active;
    assign bus.rvalid  = r_active;
    assign bus.rdata   = r_data;
    assign bus.rresp   = resp_okay;
    assign bus.rlast   = (r_cnt == 8'd0);
    assign bus.rid     = r_id;

    assign aw_go  = bus.awvalid && bus.awready;
    assign w_go   = bus.wvalid && bus.wready;
    assign ar_go  = bus.arvalid && bus.arready;
    assign r_go   = bus.rvalid && bus.rready;
    assign ar_idx = bus.araddr[idx_w+1:2]; // Word index wraps at the depth.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wstate <= w_idle;
        end else begin
            case (wstate)
                w_idle:  if (aw_go) wstate <= w_data;
                w_data:  if (w_go && bus.wlast) wstate <= w_resp;
                w_resp:  if (bus.bready) wstate <= w_idle;
                default: wstate <= w_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_go) begin
            w_idx <= bus.awaddr[idx_w+1:2];
            b_id  <= bus.awid;
        end else if (w_go) begin
            w_idx <= w_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (w_go) begin
            for (int b = 0; b < strb_w; b++) begin
                if (bus.wstrb[b]) mem[w_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_active <= 1'b0;
            r_cnt    <= 8'd0;
        end else if (ar_go) begin
            r_active <= 1'b1;
            r_cnt    <= bus.arlen;
        end else if (r_go) begin
            if (r_cnt == 8'd0) r_active <= 1'b0;
            else r_cnt <= r_cnt - 8'd1;
        end
    end

    // Next word is fetched on each accepted beat so a stall holds rdata.
    always_ff @(posedge clk) begin
        if (ar_go) begin
            r_data <= mem[ar_idx];
            r_idx  <= ar_idx + 1'b1;
            r_id   <= bus.arid;
        end else if (r_go && r_cnt != 8'd0) begin
            r_data <= mem[r_idx];
            r_idx  <= r_idx + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        aw_go |-> bus.awburst == burst_incr);

    assert property (@(posedge clk) disable iff (!rst_n)
        ar_go |-> bus.arburst == burst_incr);

endmodule

// File: logic/axi_uart.sv
`timescale 1ns/1ps

module axi_uart import axi_pkg::*; #(
    parameter int clks_per_bit = 8
) (
    input  logic clk,
    input  logic rst_n,
    axi_if.sub   bus,
    output logic tx
);

    localparam int baud_w = $clog2(clks_per_bit + 1);

    typedef enum logic [1:0] {
        w_idle,
        w_data,
        w_resp
    } wstate_e;

    wstate_e           wstate;
    logic [2:0]        aw_off;
    logic              aw_single;
    logic [id_w-1:0]   b_id, r_id;
    logic [1:0]        b_resp, r_resp;
    logic              r_active;
    logic [7:0]        r_cnt;
    logic [data_w-1:0] r_data;
    logic              busy;
    logic [8:0]        shift;
    logic [baud_w-1:0] baud_cnt;
    logic [3:0]        bit_cnt;
    logic              data_wr, status_rd, w_go, ar_go, start;

    assign data_wr   = (aw_off == uart_txdata_off) && aw_single;
    assign status_rd = (bus.araddr[2:0] == uart_status_off) && (bus.arlen == 8'd0);
    assign w_go      = bus.wvalid && bus.wready;
    assign ar_go     = bus.arvalid && bus.arready;
    assign start     = w_go && data_wr;

    assign bus.awready = (wstate == w_idle);
    assign bus.wready  = (wstate == w_data) && !(data_wr && busy); // Hold off while sending.
    assign bus.bvalid  = (wstate == w_resp);
    assign bus.bresp   = b_resp;
    assign bus.bid     = b_id;

    assign bus.arready = !r_active;
    assign bus.rvalid  = r_active;
    assign bus.rdata   = r_data;
    assign bus.rresp   = r_resp;
    assign bus.rlast   = (r_cnt == 8'd0);
    assign bus.rid     = r_id;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wstate <= w_idle;
        end else begin
            case (wstate)
                w_idle:  if (bus.awvalid) wstate <= w_data;
                w_data:  if (w_go && bus.wlast) wstate <= w_resp;
                w_resp:  if (bus.bready) wstate <= w_idle;
                default: wstate <= w_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wstate == w_idle && bus.awvalid) begin
            aw_off    <= bus.awaddr[2:0];
            aw_single <= (bus.awlen == 8'd0);
            b_id      <= bus.awid;
        end
        if (w_go && bus.wlast) b_resp <= data_wr ? resp_okay : resp_slverr;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_active <= 1'b0;
            r_cnt    <= 8'd0;
        end else if (ar_go) begin
            r_active <= 1'b1;
            r_cnt    <= bus.arlen;
        end else if (r_active && bus.rready) begin
            if (r_cnt == 8'd0) r_active <= 1'b0;
            else r_cnt <= r_cnt - 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_go) begin
            r_id   <= bus.arid;
            r_resp <= status_rd ? resp_okay : resp_slverr;
            r_data <= status_rd ? {{(data_w-1){1'b0}}, busy} : '0;
        end
    end

    // Start bit goes out with the load; bit_cnt 9 is the stop bit.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            tx       <= 1'b1;
            shift    <= '0;
            baud_cnt <= '0;
            bit_cnt  <= 4'd0;
        end else if (start) begin
            busy     <= 1'b1;
            tx       <= 1'b0;
            shift    <= {1'b1, bus.wdata[7:0]};
            baud_cnt <= '0;
            bit_cnt  <= 4'd0;
        end else if (busy) begin
            if (baud_cnt == baud_w'(clks_per_bit - 1)) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                end else begin
                    tx      <= shift[0];
                    shift   <= {1'b0, shift[8:1]};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx);

endmodule

// File: logic/soc_top.sv
`timescale 1ns/1ps

module soc_top import axi_pkg::*; #(
    parameter int sram_depth_words = 1024,
    parameter int clks_per_bit     = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              awvalid,
    output logic              awready,
    input  logic [addr_w-1:0] awaddr,
    input  logic [id_w-1:0]   awid,
    input  logic [7:0]        awlen,
    input  logic [2:0]        awsize,
    input  logic [1:0]        awburst,
    input  logic              wvalid,
    output logic              wready,
    input  logic [data_w-1:0] wdata,
    input  logic [strb_w-1:0] wstrb,
    input  logic              wlast,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    output logic [id_w-1:0]   bid,
    input  logic              arvalid,
    output logic              arready,
    input  logic [addr_w-1:0] araddr,
    input  logic [id_w-1:0]   arid,
    input  logic [7:0]        arlen,
    input  logic [2:0]        arsize,
    input  logic [1:0]        arburst,
    output logic              rvalid,
    input  logic              rready,
    output logic [data_w-1:0] rdata,
    output logic [1:0]        rresp,
    output logic              rlast,
    output logic [id_w-1:0]   rid,
    output logic              tx
);

    axi_if up_bus ();
    axi_if sram_bus ();
    axi_if uart_bus ();

    assign up_bus.awvalid = awvalid;
    assign up_bus.awaddr  = awaddr;
    assign up_bus.awid    = awid;
    assign up_bus.awlen   = awlen;
    assign up_bus.awsize  = awsize;
    assign up_bus.awburst = awburst;
    assign up_bus.wvalid  = wvalid;
    assign up_bus.wdata   = wdata;
    assign up_bus.wstrb   = wstrb;
    assign up_bus.wlast   = wlast;
    assign up_bus.bready  = bready;
    assign up_bus.arvalid = arvalid;
    assign up_bus.araddr  = araddr;
    assign up_bus.arid    = arid;
    assign up_bus.arlen   = arlen;
    assign up_bus.arsize  = arsize;
    assign up_bus.arburst = arburst;
    assign up_bus.rready  = rready;

    assign awready = up_bus.awready;
    assign wready  = up_bus.wready;
    assign bvalid  = up_bus.bvalid;
    assign bresp   = up_bus.bresp;
    assign bid     = up_bus.bid;
    assign arready = up_bus.arready;
    assign rvalid  = up_bus.rvalid;
    assign rdata   = up_bus.rdata;
    assign rresp   = up_bus.rresp;
    assign rlast   = up_bus.rlast;
    assign rid     = up_bus.rid;

    axi_bridge axi_bridge_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .up       (up_bus),
        .sram_bus (sram_bus),
        .uart_bus (uart_bus)
    );

    axi_sram #(
        .sram_depth_words (sram_depth_words)
    ) axi_sram_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (sram_bus)
    );

    axi_uart #(
        .clks_per_bit (clks_per_bit)
    ) axi_uart_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (uart_bus),
        .tx    (tx)
    );

endmodule

// File: testbench/tb_soc_top.sv
`timescale 1ns/1ps

module tb_soc_top import axi_pkg::*; ();

    localparam int clks_per_bit = 4;
    localparam int max_cycles   = 6000;

    logic        clk, rst_n;
    logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  awid, wstrb, bid, arid, rid;
    logic [7:0]  awlen, arlen;
    logic [2:0]  awsize, arsize;
    logic [1:0]  awburst, arburst, bresp, rresp;
    logic        arvalid, arready, rvalid, rready, rlast, tx;

    int          errors = 0;
    int          cycles = 0;
    int          seed = 43109;
    int          w_stalls;
    logic [31:0] ref_mem [logic [31:0]];
    logic [31:0] wbuf [16];
    logic [3:0]  sbuf [16];
    logic [31:0] rbuf [16];
    logic [1:0]  rrbuf [16];
    logic        lbuf [16];
    logic [3:0]  ibuf [16];
    logic [7:0]  rx_q [$];
    logic [1:0]  b_resp_got;
    logic [3:0]  b_id_got;

    soc_top #(
        .clks_per_bit (clks_per_bit)
    ) soc_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic show_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        errors++;
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic record_failure(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [31:0] word;
        word = ref_mem.exists(addr) ? ref_mem[addr] : 32'h0;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
        end
        ref_mem[addr] = word;
    endtask

    task automatic fill_random(input int len, input bit full);
        for (int i = 0; i <= len; i++) begin
            wbuf[i] = $random(seed);
            sbuf[i] = full ? 4'hF : 4'($random(seed));
        end
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [3:0] id, input logic [7:0] len);
        @(posedge clk);
        #2;
        awvalid = 1'b1;
        awaddr  = addr;
        awid    = id;
        awlen   = len;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        #2;
        awvalid  = 1'b0;
        w_stalls = 0;
        for (int i = 0; i <= len; i++) begin
            wvalid = 1'b1;
            wdata  = wbuf[i];
            wstrb  = sbuf[i];
            wlast  = (i == len);
            @(negedge clk);
            while (!wready) begin
                w_stalls++;
                @(negedge clk);
            end
            @(posedge clk);
            #2;
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        b_resp_got = bresp;
        b_id_got   = bid;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    // Stall drops rready on every third cycle.
    task automatic axi_read(input logic [31:0] addr, input logic [3:0] id, input logic [7:0] len,
                            input bit stall);
        int n;
        int k;
        n = 0;
        k = 0;
        @(posedge clk);
        #2;
        arvalid = 1'b1;
        araddr  = addr;
        arid    = id;
        arlen   = len;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        while (n <= len) begin
            rready = !stall || (k % 3 != 1);
            k++;
            @(negedge clk);
            if (rvalid && rready) begin
                rbuf[n]  = rdata;
                rrbuf[n] = rresp;
                lbuf[n]  = rlast;
                ibuf[n]  = rid;
                n++;
            end
            @(posedge clk);
            #2;
        end
        rready = 1'b0;
    endtask

    task automatic sram_write_check(input logic [31:0] addr, input logic [3:0] id,
                                    input logic [7:0] len);
        axi_write(addr, id, len);
        if (b_resp_got !== resp_okay) show_mismatch("SRAM bresp", b_resp_got, resp_okay);
        if (b_id_got !== id) show_mismatch("SRAM bid", b_id_got, id);
        for (int i = 0; i <= len; i++) model_write(addr + 32'(4 * i), wbuf[i], sbuf[i]);
    endtask

    task automatic sram_read_check(input logic [31:0] addr, input logic [3:0] id,
                                   input logic [7:0] len, input bit stall);
        logic [31:0] a;
        axi_read(addr, id, len, stall);
        for (int i = 0; i <= len; i++) begin
            a = addr + 32'(4 * i);
            if (!ref_mem.exists(a)) begin
                record_failure($sformatf("SRAM read of word %h that was never written", a));
            end else if (rbuf[i] !== ref_mem[a]) begin
                show_mismatch($sformatf("SRAM rdata at %h", a), rbuf[i], ref_mem[a]);
            end
            if (rrbuf[i] !== resp_okay) show_mismatch("SRAM rresp", rrbuf[i], resp_okay);
            if (ibuf[i] !== id) show_mismatch("SRAM rid", ibuf[i], id);
            if (lbuf[i] !== (i == len)) show_mismatch("SRAM rlast", lbuf[i], i == len);
        end
    endtask

    // Polls at the falling edge, then samples each bit near its middle.
    task automatic receive_frame();
        logic [7:0] data;
        @(negedge clk);
        while (tx !== 1'b0) @(negedge clk);
        repeat (clks_per_bit / 2) @(negedge clk);
        if (tx !== 1'b0) record_failure("UART start bit ended early");
        for (int b = 0; b < 8; b++) begin
            repeat (clks_per_bit) @(negedge clk);
            data[b] = tx;
        end
        repeat (clks_per_bit) @(negedge clk);
        if (tx !== 1'b1) record_failure("UART stop bit was low");
        rx_q.push_back(data);
    endtask

    task automatic wait_bytes(input int n);
        while (rx_q.size() < n) @(negedge clk);
    endtask

    task automatic test_sram_single();
        for (int i = 0; i < 4; i++) begin
            fill_random(0, 1'b1);
            sram_write_check(sram_base + 32'(4 * i), 4'(i + 1), 8'd0);
        end
        wbuf[0] = 32'hDEAD_BEEF;
        sbuf[0] = 4'b0101;
        sram_write_check(sram_base, 4'd7, 8'd0);
        wbuf[0] = 32'h1234_5678;
        sbuf[0] = 4'b1000;
        sram_write_check(sram_base + 32'h4, 4'd8, 8'd0);
        wbuf[0] = 32'hCAFE_F00D;
        sbuf[0] = 4'b0011;
        sram_write_check(sram_base + 32'h8, 4'd9, 8'd0);
        for (int i = 0; i < 4; i++) sram_read_check(sram_base + 32'(4 * i), 4'(10 + i), 8'd0, 1'b0);
    endtask

    task automatic test_sram_burst();
        fill_random(3, 1'b1);
        sram_write_check(sram_base + 32'h40, 4'd3, 8'd3);
        sram_read_check(sram_base + 32'h40, 4'd4, 8'd3, 1'b1);
    endtask

    task automatic test_uart_tx();
        rx_q.delete();
        wbuf[0] = 32'h0000_00A5;
        sbuf[0] = 4'b0001;
        axi_write(uart_base + 32'(uart_txdata_off), 4'd2, 8'd0);
        if (b_resp_got !== resp_okay) show_mismatch("UART bresp", b_resp_got, resp_okay);
        if (b_id_got !== 4'd2) show_mismatch("UART bid", b_id_got, 4'd2);
        axi_read(uart_base + 32'(uart_status_off), 4'd3, 8'd0, 1'b0);
        if (rrbuf[0] !== resp_okay) show_mismatch("UART status rresp", rrbuf[0], resp_okay);
        if (rbuf[0] !== 32'd1) show_mismatch("UART status while sending", rbuf[0], 32'd1);
        wait_bytes(1);
        if (rx_q[0] !== 8'hA5) show_mismatch("UART frame byte", rx_q[0], 8'hA5);
        repeat (clks_per_bit) @(posedge clk); // Rest of the stop bit.
        axi_read(uart_base + 32'(uart_status_off), 4'd3, 8'd0, 1'b0);
        if (rbuf[0] !== 32'd0) show_mismatch("UART status after frame", rbuf[0], 32'd0);
    endtask

    task automatic test_uart_backpressure();
        rx_q.delete();
        sbuf[0] = 4'b0001;
        wbuf[0] = 32'h0000_003C;
        axi_write(uart_base, 4'd4, 8'd0);
        if (b_resp_got !== resp_okay) show_mismatch("first UART bresp", b_resp_got, resp_okay);
        wbuf[0] = 32'h0000_00C3;
        axi_write(uart_base, 4'd5, 8'd0);
        if (b_resp_got !== resp_okay) show_mismatch("second UART bresp", b_resp_got, resp_okay);
        if (w_stalls == 0) record_failure("second UART write was not held off during the first frame");
        axi_read(uart_base, 4'd6, 8'd0, 1'b0);
        if (rrbuf[0] !== resp_slverr) show_mismatch("UART offset 0 rresp", rrbuf[0], resp_slverr);
        wait_bytes(2);
        if (rx_q[0] !== 8'h3C) show_mismatch("first UART byte", rx_q[0], 8'h3C);
        if (rx_q[1] !== 8'hC3) show_mismatch("second UART byte", rx_q[1], 8'hC3);
    endtask

    task automatic test_decode_error();
        fill_random(0, 1'b1);
        axi_write(32'h4000_0000, 4'd9, 8'd0);
        if (b_resp_got !== resp_decerr) show_mismatch("unmapped bresp", b_resp_got, resp_decerr);
        if (b_id_got !== 4'd9) show_mismatch("unmapped bid", b_id_got, 4'd9);
        axi_read(32'h4000_0000, 4'd10, 8'd3, 1'b0);
        for (int i = 0; i < 4; i++) begin
            if (rrbuf[i] !== resp_decerr) show_mismatch("unmapped rresp", rrbuf[i], resp_decerr);
            if (rbuf[i] !== 32'd0) show_mismatch("unmapped rdata", rbuf[i], 32'd0);
            if (ibuf[i] !== 4'd10) show_mismatch("unmapped rid", ibuf[i], 4'd10);
            if (lbuf[i] !== (i == 3)) show_mismatch("unmapped rlast", lbuf[i], i == 3);
        end
        fill_random(0, 1'b1);
        sram_write_check(sram_base + 32'h80, 4'd11, 8'd0);
        sram_read_check(sram_base + 32'h80, 4'd12, 8'd0, 1'b0);
    endtask

    task automatic test_random_traffic();
        logic [31:0] base;
        logic [7:0]  tx_byte;
        logic [7:0]  sent [$];
        int          off;
        int          len;
        base = sram_base + 32'h100; // 64 words, filled first.
        rx_q.delete();
        for (int f = 0; f < 4; f++) begin
            fill_random(15, 1'b1);
            sram_write_check(base + 32'(64 * f), 4'(f), 8'd15);
        end
        for (int i = 0; i < 40; i++) begin
            off = $unsigned($random(seed)) % 61;
            len = $unsigned($random(seed)) % 4;
            if (i % 10 == 5) begin
                sram_read_check(base + 32'(4 * off), 4'(i), 8'(len), 1'b0);
                tx_byte = 8'($random(seed));
                sent.push_back(tx_byte);
                wbuf[0] = {24'h0, tx_byte};
                sbuf[0] = 4'b0001;
                axi_write(uart_base, 4'hE, 8'd0);
                if (b_resp_got !== resp_okay) show_mismatch("UART bresp", b_resp_got, resp_okay);
                sram_read_check(base, 4'hD, 8'd0, 1'b0);
            end else if ($random(seed) & 1) begin
                fill_random(len, 1'b0);
                sram_write_check(base + 32'(4 * off), 4'(i), 8'(len));
            end else begin
                sram_read_check(base + 32'(4 * off), 4'(i), 8'(len), i[0]);
            end
        end
        wait_bytes(sent.size());
        foreach (sent[j]) begin
            if (rx_q[j] !== sent[j]) show_mismatch("interleaved UART byte", rx_q[j], sent[j]);
        end
    endtask

    initial begin
        @(posedge rst_n);
        forever receive_frame();
    end

    initial begin
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        awid    = '0;
        awlen   = '0;
        awsize  = 3'd2; // Always whole words.
        awburst = burst_incr;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        arid    = '0;
        arlen   = '0;
        arsize  = 3'd2;
        arburst = burst_incr;
        rready  = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        if (bvalid !== 1'b0 || rvalid !== 1'b0) record_failure("a response valid is high after reset");
        if (tx !== 1'b1) record_failure("tx is not high after reset");
        test_sram_single();
        test_sram_burst();
        test_uart_tx();
        test_uart_backpressure();
        test_decode_error();
        test_random_traffic();
        repeat (4) @(posedge clk);
        $display("Run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
logic/axi_pkg.sv
logic/axi_if.sv
logic/axi_bridge.sv
logic/axi_sram.sv
logic/axi_uart.sv
logic/soc_top.sv
testbench/tb_soc_top.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_soc_top
FILELIST = project.f
BUILD    = obj_dir

.PHONY: sim clean

# The run passes only if the pass message shows up in the output.
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD)
